// ==== src/fpu_pkg.sv ====
//////////////////////////////////////////////////
// fpu_pkg
// shared widths, operation encoding and the
// single-precision word types of the FPU
//////////////////////////////////////////////////

package fpu_pkg;

  localparam int word_width_gp     = 32;
  localparam int reg_addr_width_gp = 5;

  // operations that write back to the fp register file
  typedef enum logic [2:0] {
    op_fsgnj     = 3'd0,
    op_fsgnjn    = 3'd1,
    op_fsgnjx    = 3'd2,
    op_fmin      = 3'd3,
    op_fmax      = 3'd4,
    op_fmv_w_x   = 3'd5,
    op_fcvt_s_w  = 3'd6,
    op_fcvt_s_wu = 3'd7
  } fp_op_e;

  // ieee 754 binary32 fields
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_s;

  // one operand word, seen as a float or as an integer
  typedef union packed {
    fp32_s                    fp;
    logic [word_width_gp-1:0] bits;
  } fp_word_u;

  // quiet nan returned by fmin/fmax when both inputs are nan
  localparam logic [word_width_gp-1:0] canonical_nan_gc = 32'h7fc0_0000;

endpackage

// ==== src/fpu_result_if.sv ====
//////////////////////////////////////////////////
// fpu_result_if
// result word and destination register index
// handed from the pipeline to the result queue
//////////////////////////////////////////////////

interface fpu_result_if import fpu_pkg::*; ();

  logic                         v;
  logic                         ready;
  logic [word_width_gp-1:0]     z;
  logic [reg_addr_width_gp-1:0] rd;

  modport producer (output v, output z, output rd, input ready);

  modport consumer (input v, input z, input rd, output ready);

endinterface

// ==== src/fpu_float_aux.sv ====
//////////////////////////////////////////////////
// fpu_float_aux
// sign injection, min/max and fmv.w.x
// one register stage, held while en_i is low
//////////////////////////////////////////////////

module fpu_float_aux import fpu_pkg::*; (
    input  logic                     clk_i
  , input  logic                     reset_i
  , input  logic                     en_i

  , input  logic                     v_i
  , input  fp_op_e                   op_i
  , input  fp_word_u                 a_i
  , input  fp_word_u                 b_i

  , output logic                     v_o
  , output logic [word_width_gp-1:0] z_o
);

  logic a_nan;
  logic b_nan;
  logic a_lt_b;
  logic [word_width_gp-1:0] minmax;
  logic [word_width_gp-1:0] result;
  logic v_r;
  logic [word_width_gp-1:0] z_r;

  assign a_nan = (a_i.fp.exponent == 8'hff) && (a_i.fp.mantissa != '0);
  assign b_nan = (b_i.fp.exponent == 8'hff) && (b_i.fp.mantissa != '0);

  // sign-magnitude compare with -0 below +0
  always_comb begin
    if (a_i.fp.sign != b_i.fp.sign) begin
      a_lt_b = a_i.fp.sign;
    end
    else if (a_i.fp.sign) begin
      a_lt_b = a_i.bits[30:0] > b_i.bits[30:0];
    end
    else begin
      a_lt_b = a_i.bits[30:0] < b_i.bits[30:0];
    end
  end

  always_comb begin
    if (a_nan && b_nan) begin
      minmax = canonical_nan_gc;
    end
    else if (a_nan) begin
      minmax = b_i.bits;
    end
    else if (b_nan) begin
      minmax = a_i.bits;
    end
    else if (op_i == op_fmin) begin
      minmax = a_lt_b ? a_i.bits : b_i.bits;
    end
    else begin
      minmax = a_lt_b ? b_i.bits : a_i.bits;
    end
  end

  always_comb begin
    case (op_i)
      op_fsgnj:  result = {b_i.fp.sign, a_i.bits[30:0]};
      op_fsgnjn: result = {~b_i.fp.sign, a_i.bits[30:0]};
      op_fsgnjx: result = {a_i.fp.sign ^ b_i.fp.sign, a_i.bits[30:0]};
      op_fmin,
      op_fmax:   result = minmax;
      // fmv.w.x moves the bit pattern unchanged
      default:   result = a_i.bits;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end
    else if (en_i) begin
      v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      z_r <= result;
    end
  end

  assign v_o = v_r;
  assign z_o = z_r;

endmodule

// ==== src/fpu_i2f.sv ====
//////////////////////////////////////////////////
// fpu_i2f
// signed/unsigned integer to single-precision
// float, round to nearest even, one register stage
//////////////////////////////////////////////////

module fpu_i2f import fpu_pkg::*; (
    input  logic                     clk_i
  , input  logic                     reset_i
  , input  logic                     en_i

  , input  logic                     v_i
  , input  logic                     signed_i
  , input  fp_word_u                 a_i

  , output logic                     v_o
  , output logic [word_width_gp-1:0] z_o
);

  // position of the leading one counted from bit 31
  function automatic logic [4:0] count_lz(input logic [31:0] x);
    logic [4:0] n;
    n = 5'd0;
    // lowest set bit first, so the highest one wins
    for (int i = 0; i < 32; i++) begin
      if (x[i]) begin
        n = 5'(31 - i);
      end
    end
    return n;
  endfunction

  logic        sign;
  logic [31:0] mag;
  logic [4:0]  lz;
  logic [31:0] norm;
  logic [7:0]  exp_raw;
  logic        guard;
  logic        sticky;
  logic        round_up;
  logic [30:0] rounded;
  logic [word_width_gp-1:0] result;
  logic v_r;
  logic [word_width_gp-1:0] z_r;

  assign sign = signed_i & a_i.bits[31];
  assign mag  = sign ? -a_i.bits : a_i.bits;
  assign lz   = count_lz(mag);
  assign norm = mag << lz;

  // bias 127 plus 31 for the leading one at bit 31
  assign exp_raw = 8'd158 - 8'(lz);

  assign guard    = norm[7];
  assign sticky   = |norm[6:0];
  assign round_up = guard & (sticky | norm[8]);

  // mantissa overflow carries straight into the exponent
  assign rounded = {exp_raw, norm[30:8]} + 31'(round_up);

  assign result = (mag == '0) ? '0 : {sign, rounded};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end
    else if (en_i) begin
      v_r <= v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      z_r <= result;
    end
  end

  assign v_o = v_r;
  assign z_o = z_r;

endmodule

// ==== src/fpu_float.sv ====
//////////////////////////////////////////////////
// fpu_float
// three-stage fp writeback pipeline
// dispatches to the aux and i2f units, merges
// their results and stalls on queue back-pressure
//////////////////////////////////////////////////

module fpu_float import fpu_pkg::*; (
    input  logic                         clk_i
  , input  logic                         reset_i

  , input  logic                         v_i
  , input  fp_op_e                       op_i
  , input  logic [word_width_gp-1:0]     rs1_i
  , input  logic [word_width_gp-1:0]     rs2_i
  , input  logic [reg_addr_width_gp-1:0] rd_i
  , output logic                         ready_o

  , fpu_result_if.producer               res
);

  logic stall;

  logic aux_v_li;
  logic aux_v_lo;
  logic [word_width_gp-1:0] aux_z_lo;

  logic i2f_v_li;
  logic i2f_signed_li;
  logic i2f_v_lo;
  logic [word_width_gp-1:0] i2f_z_lo;

  logic v_2_r;
  logic v_3_r;
  logic [word_width_gp-1:0] result_2_r;
  logic [word_width_gp-1:0] result_3_r;
  logic [reg_addr_width_gp-1:0] rd_1_r;
  logic [reg_addr_width_gp-1:0] rd_2_r;
  logic [reg_addr_width_gp-1:0] rd_3_r;

  // output held and not taken by the queue
  assign stall   = res.v & ~res.ready;
  assign ready_o = ~stall;

  // steer the valid to one unit
  always_comb begin
    aux_v_li      = 1'b0;
    i2f_v_li      = 1'b0;
    i2f_signed_li = 1'b0;
    case (op_i)
      op_fcvt_s_w: begin
        i2f_v_li      = v_i;
        i2f_signed_li = 1'b1;
      end
      op_fcvt_s_wu: begin
        i2f_v_li = v_i;
      end
      default: begin
        aux_v_li = v_i;
      end
    endcase
  end

  fpu_float_aux aux (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .en_i    (~stall)
    , .v_i     (aux_v_li)
    , .op_i    (op_i)
    , .a_i     (rs1_i)
    , .b_i     (rs2_i)
    , .v_o     (aux_v_lo)
    , .z_o     (aux_z_lo)
  );

  fpu_i2f i2f (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .en_i     (~stall)
    , .v_i      (i2f_v_li)
    , .signed_i (i2f_signed_li)
    , .a_i      (rs1_i)
    , .v_o      (i2f_v_lo)
    , .z_o      (i2f_z_lo)
  );

  // merge and stage 3
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_2_r <= 1'b0;
      v_3_r <= 1'b0;
    end
    else if (~stall) begin
      v_2_r <= aux_v_lo | i2f_v_lo;
      v_3_r <= v_2_r;
    end
  end

  always_ff @(posedge clk_i) begin
    if (~stall) begin
      result_2_r <= i2f_v_lo ? i2f_z_lo : aux_z_lo;
      result_3_r <= result_2_r;
    end
  end

  // rd travels alongside the data
  always_ff @(posedge clk_i) begin
    if (~stall) begin
      rd_1_r <= rd_i;
      rd_2_r <= rd_1_r;
      rd_3_r <= rd_2_r;
    end
  end

  assign res.v  = v_3_r;
  assign res.z  = result_3_r;
  assign res.rd = rd_3_r;

endmodule

// ==== src/fpu_result_fifo.sv ====
//////////////////////////////////////////////////
// fpu_result_fifo
// in-order result queue between the pipeline
// and the writeback port, valid/yumi on the output
//////////////////////////////////////////////////

module fpu_result_fifo import fpu_pkg::*; #(
    parameter int fifo_depth_p = 4
) (
    input  logic                         clk_i
  , input  logic                         reset_i

  , fpu_result_if.consumer               in

  , output logic                         v_o
  , output logic [word_width_gp-1:0]     z_o
  , output logic [reg_addr_width_gp-1:0] rd_o
  , input  logic                         yumi_i
);

  localparam int ptr_width_lp   = (fifo_depth_p > 1) ? $clog2(fifo_depth_p) : 1;
  localparam int count_width_lp = $clog2(fifo_depth_p + 1);

  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] p);
    return (p == ptr_width_lp'(fifo_depth_p - 1)) ? '0 : p + 1'b1;
  endfunction

  logic [word_width_gp-1:0]     z_mem  [fifo_depth_p];
  logic [reg_addr_width_gp-1:0] rd_mem [fifo_depth_p];
  logic [ptr_width_lp-1:0]      rptr_r;
  logic [ptr_width_lp-1:0]      wptr_r;
  logic [count_width_lp-1:0]    count_r;
  logic full;
  logic enq;
  logic deq;

  assign full     = (count_r == count_width_lp'(fifo_depth_p));
  assign in.ready = ~full;
  assign enq      = in.v & ~full;
  // head leaves when writeback takes it
  assign deq      = yumi_i & v_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rptr_r  <= '0;
      wptr_r  <= '0;
      count_r <= '0;
    end
    else begin
      if (enq) begin
        wptr_r <= next_ptr(wptr_r);
      end
      if (deq) begin
        rptr_r <= next_ptr(rptr_r);
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      z_mem[wptr_r]  <= in.z;
      rd_mem[wptr_r] <= in.rd;
    end
  end

  assign v_o  = (count_r != '0);
  assign z_o  = z_mem[rptr_r];
  assign rd_o = rd_mem[rptr_r];

endmodule

// ==== src/fpu_top.sv ====
//////////////////////////////////////////////////
// fpu_top
// fp writeback unit: pipeline plus result queue
// valid/ready on issue, valid/yumi on writeback
//////////////////////////////////////////////////

module fpu_top import fpu_pkg::*; #(
    parameter int fifo_depth_p = 4
) (
    input  logic                         clk_i
  , input  logic                         reset_i

  , input  logic                         v_i
  , input  fp_op_e                       op_i
  , input  logic [word_width_gp-1:0]     rs1_i
  , input  logic [word_width_gp-1:0]     rs2_i
  , input  logic [reg_addr_width_gp-1:0] rd_i
  , output logic                         ready_o

  , output logic                         v_o
  , output logic [word_width_gp-1:0]     z_o
  , output logic [reg_addr_width_gp-1:0] rd_o
  , input  logic                         yumi_i
);

  fpu_result_if res_if ();

  fpu_float pipe (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .v_i     (v_i)
    , .op_i    (op_i)
    , .rs1_i   (rs1_i)
    , .rs2_i   (rs2_i)
    , .rd_i    (rd_i)
    , .ready_o (ready_o)
    , .res     (res_if.producer)
  );

  // absorbs results while writeback is held off
  fpu_result_fifo #(
      .fifo_depth_p (fifo_depth_p)
  ) fifo (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .in      (res_if.consumer)
    , .v_o     (v_o)
    , .z_o     (z_o)
    , .rd_o    (rd_o)
    , .yumi_i  (yumi_i)
  );

endmodule

// ==== tests/fpu_checker.sv ====
//////////////////////////////////////////////////
// fpu_checker
// writeback handshake properties, bound into
// every fpu_top instance
//////////////////////////////////////////////////

module fpu_checker import fpu_pkg::*; (
    input  logic                         clk_i
  , input  logic                         reset_i
  , input  logic                         v_o
  , input  logic [word_width_gp-1:0]     z_o
  , input  logic [reg_addr_width_gp-1:0] rd_o
  , input  logic                         yumi_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int assert_fails = 0;

  // an offered result waits unchanged until it is taken
  hold_until_taken: assert property (@(posedge clk_i) disable iff (reset_i)
      v_o && !yumi_i |=> v_o && $stable(z_o) && $stable(rd_o))
    else begin
      assert_fails++;
      $error("writeback result changed before it was taken");
    end

  empty_after_reset: assert property (@(posedge clk_i) reset_i |=> !v_o)
    else begin
      assert_fails++;
      $error("v_o high in the cycle after reset");
    end

  yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
      yumi_i |-> v_o)
    else begin
      assert_fails++;
      $error("yumi_i raised without v_o");
    end

endmodule

bind fpu_top fpu_checker chk (
    .clk_i   (clk_i)
  , .reset_i (reset_i)
  , .v_o     (v_o)
  , .z_o     (z_o)
  , .rd_o    (rd_o)
  , .yumi_i  (yumi_i)
);

// ==== tests/fpu_tb.sv ====
//////////////////////////////////////////////////
// fpu_tb
// directed tests for the fp writeback unit with a
// reference model, in-order scoreboard and watchdog
//////////////////////////////////////////////////

module fpu_tb import fpu_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int fifo_depth_lp = 4;
  // sign 36, min/max 28, convert 36, stream 64, back-pressure 16, reset 14
  localparam int planned_ops_lp = 194;

  logic                         clk_i;
  logic                         reset_i;
  logic                         v_i;
  fp_op_e                       op_i;
  logic [word_width_gp-1:0]     rs1_i;
  logic [word_width_gp-1:0]     rs2_i;
  logic [reg_addr_width_gp-1:0] rd_i;
  logic                         ready_o;
  logic                         v_o;
  logic [word_width_gp-1:0]     z_o;
  logic [reg_addr_width_gp-1:0] rd_o;
  logic                         yumi_i;

  integer seed;
  int errors;
  int checks;
  int ops_done;
  int errors_at_start;
  int ops_at_start;
  int total_errors;
  // 0 holds writeback off, 1 takes every result, 2 takes at random
  int yumi_mode;
  logic [reg_addr_width_gp-1:0] rd_next;
  fp_word_u                     exp_z_q [$];
  logic [reg_addr_width_gp-1:0] exp_rd_q [$];

  fpu_top #(
      .fifo_depth_p (fifo_depth_lp)
  ) uut (
      .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .v_i     (v_i)
    , .op_i    (op_i)
    , .rs1_i   (rs1_i)
    , .rs2_i   (rs2_i)
    , .rd_i    (rd_i)
    , .ready_o (ready_o)
    , .v_o     (v_o)
    , .z_o     (z_o)
    , .rd_o    (rd_o)
    , .yumi_i  (yumi_i)
  );

  always #10 clk_i = ~clk_i;

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic is_nan(input fp_word_u x);
    return (x.fp.exponent == 8'hff) && (x.fp.mantissa != '0);
  endfunction

  // maps floats onto unsigned keys in numeric order with -0 below +0
  function automatic logic [31:0] order_key(input fp_word_u x);
    return x.fp.sign ? ~x.bits : (x.bits | 32'h8000_0000);
  endfunction

  // exact through a double, then round to nearest even on 23 bits
  function automatic logic [31:0] int_to_float(input logic [31:0] a, input logic is_signed);
    longint   v;
    real      r;
    logic [63:0] d;
    logic     up;
    fp_word_u w;
    v = is_signed ? longint'($signed(a)) : longint'({32'b0, a});
    if (v == 0) begin
      return '0;
    end
    r = real'(v);
    d = $realtobits(r);
    w.fp.sign     = d[63];
    w.fp.exponent = 8'(d[62:52] - 11'd896);
    w.fp.mantissa = d[51:29];
    up = d[28] & ((|d[27:0]) | d[29]);
    w.bits = w.bits + 32'(up);
    return w.bits;
  endfunction

  function automatic fp_word_u expected_result(input fp_op_e op, input fp_word_u a,
                                               input fp_word_u b);
    fp_word_u r;
    logic     a_low;
    r = a;
    case (op)
      op_fsgnj:  r.fp.sign = b.fp.sign;
      op_fsgnjn: r.fp.sign = ~b.fp.sign;
      op_fsgnjx: r.fp.sign = a.fp.sign ^ b.fp.sign;
      op_fmin,
      op_fmax: begin
        a_low = order_key(a) < order_key(b);
        if (is_nan(a) && is_nan(b)) begin
          r.bits = canonical_nan_gc;
        end
        else if (is_nan(a)) begin
          r = b;
        end
        else if (!is_nan(b)) begin
          r = ((op == op_fmin) == a_low) ? a : b;
        end
      end
      op_fcvt_s_w:  r.bits = int_to_float(a.bits, 1'b1);
      op_fcvt_s_wu: r.bits = int_to_float(a.bits, 1'b0);
      default:      r = a;
    endcase
    return r;
  endfunction

  task automatic check_word(input string name, input fp_word_u got, input fp_word_u exp);
    checks++;
    if (got.bits !== exp.bits) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got.bits, exp.bits, $time);
    end
  endtask

  task automatic check_rd(input string name, input logic [reg_addr_width_gp-1:0] got,
                          input logic [reg_addr_width_gp-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // starts on a falling edge and returns on the one after the transfer
  task automatic issue(input fp_op_e op, input logic [31:0] a, input logic [31:0] b);
    fp_word_u wa;
    fp_word_u wb;
    wa.bits = a;
    wb.bits = b;
    v_i   = 1'b1;
    op_i  = op;
    rs1_i = a;
    rs2_i = b;
    rd_i  = rd_next;
    while (!ready_o) begin
      @(negedge clk_i);
    end
    exp_z_q.push_back(expected_result(op, wa, wb));
    exp_rd_q.push_back(rd_next);
    rd_next = rd_next + 1'b1;
    ops_done++;
    @(negedge clk_i);
    v_i = 1'b0;
  endtask

  task automatic drain_results(input int limit);
    int n;
    n = 0;
    while (exp_z_q.size() != 0 && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_z_q.size() != 0) begin
      errors++;
      $display("%0d results still missing after %0d cycles", exp_z_q.size(), limit);
    end
  endtask

  task automatic mark_start();
    errors_at_start = errors;
    ops_at_start    = ops_done;
  endtask

  task automatic report_test(input string name);
    $display("%-22s %3d ops  %0d errors", name, ops_done - ops_at_start,
             errors - errors_at_start);
  endtask

  task automatic sign_injection();
    logic [31:0] special [6];
    mark_start();
    special = '{32'h0000_0000, 32'h8000_0000, 32'h7f80_0000,
                32'hff80_0000, 32'h7fc0_0000, 32'hbf80_0000};
    yumi_mode = 1;
    for (int k = 0; k < 3; k++) begin
      for (int i = 0; i < 12; i++) begin
        if (i < 6) begin
          issue(fp_op_e'(k), special[i], special[5-i]);
        end
        else begin
          issue(fp_op_e'(k), rand_word(), rand_word());
        end
      end
    end
    drain_results(100);
    report_test("sign injection");
  endtask

  task automatic min_max_pairs();
    logic [31:0] pa [10];
    logic [31:0] pb [10];
    logic [31:0] a;
    logic [31:0] b;
    mark_start();
    // ordered pairs, signed zeros, one nan, two nans, infinities
    pa = '{32'h3f80_0000, 32'hbf80_0000, 32'hc000_0000, 32'h8000_0000, 32'h0000_0000,
           32'h7fc0_0000, 32'h3f80_0000, 32'h7fc0_0000, 32'h7f80_0000, 32'h0000_0000};
    pb = '{32'h4000_0000, 32'h4000_0000, 32'hbf80_0000, 32'h0000_0000, 32'h8000_0000,
           32'h3f80_0000, 32'h7f80_0001, 32'h7f80_0001, 32'hff80_0000, 32'h0000_0000};
    for (int i = 0; i < 14; i++) begin
      a = (i < 10) ? pa[i] : rand_word();
      b = (i < 10) ? pb[i] : rand_word();
      issue(op_fmin, a, b);
      issue(op_fmax, a, b);
    end
    drain_results(100);
    report_test("min and max");
  endtask

  task automatic moves_and_converts();
    logic [31:0] vals [10];
    logic [31:0] a;
    mark_start();
    // 0x01000001 and 0x01000003 are exact ties
    vals = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff,
             32'h0100_0001, 32'h0100_0003, 32'hffff_fffd, 32'h00ff_ffff, 32'h8123_4567};
    for (int i = 0; i < 4; i++) begin
      issue(op_fmv_w_x, rand_word(), rand_word());
    end
    for (int i = 0; i < 16; i++) begin
      a = (i < 10) ? vals[i] : rand_word();
      issue(op_fcvt_s_w, a, '0);
      issue(op_fcvt_s_wu, a, '0);
    end
    drain_results(100);
    report_test("moves and conversions");
  endtask

  task automatic stream_back_to_back();
    logic [2:0] op_bits;
    mark_start();
    yumi_mode = 1;
    for (int i = 0; i < 64; i++) begin
      check_flag("ready_o", ready_o, 1'b1);
      op_bits = 3'(rand_word());
      issue(fp_op_e'(op_bits), rand_word(), rand_word());
    end
    drain_results(100);
    report_test("streaming");
  endtask

  task automatic back_pressure_drain();
    logic [2:0] op_bits;
    int         accepted;
    mark_start();
    yumi_mode = 0;
    accepted  = 0;
    while (ready_o && accepted < 16) begin
      op_bits = 3'(rand_word());
      issue(fp_op_e'(op_bits), rand_word(), rand_word());
      accepted++;
    end
    checks++;
    if (ready_o) begin
      errors++;
      $display("ready_o never fell while writeback was held off");
    end
    else if (accepted < fifo_depth_lp || accepted > fifo_depth_lp + 3) begin
      errors++;
      $display("%0d operations accepted before ready_o fell, expected %0d to %0d",
               accepted, fifo_depth_lp, fifo_depth_lp + 3);
    end
    yumi_mode = 2;
    drain_results(400);
    report_test("back-pressure");
  endtask

  task automatic reset_mid_stream();
    logic [2:0] op_bits;
    mark_start();
    yumi_mode = 1;
    for (int i = 0; i < 14; i++) begin
      // reset lands with the last four still in flight
      if (i == 6) begin
        reset_i   = 1'b1;
        yumi_mode = 0;
        exp_z_q.delete();
        exp_rd_q.delete();
        repeat (2) @(negedge clk_i);
        reset_i = 1'b0;
        check_flag("v_o", v_o, 1'b0);
        check_flag("ready_o", ready_o, 1'b1);
        yumi_mode = 1;
      end
      op_bits = 3'(rand_word());
      issue(fp_op_e'(op_bits), rand_word(), rand_word());
    end
    drain_results(100);
    report_test("reset mid-stream");
  endtask

  // scoreboard pops one expected entry per accepted result
  always @(posedge clk_i) begin
    if (!reset_i && v_o && yumi_i) begin
      if (exp_z_q.size() == 0) begin
        errors++;
        $display("result taken with no operation outstanding, rd_o %h z_o %h", rd_o, z_o);
      end
      else begin
        check_word("z_o", z_o, exp_z_q.pop_front());
        check_rd("rd_o", rd_o, exp_rd_q.pop_front());
      end
    end
  end

  always @(negedge clk_i) begin
    case (yumi_mode)
      0:       yumi_i = 1'b0;
      1:       yumi_i = v_o;
      default: yumi_i = v_o && ($random(seed) % 2 != 0);
    endcase
  end

  initial begin
    repeat (planned_ops_lp * 40) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, run did not complete",
             planned_ops_lp * 40);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed      = 90066;
    errors    = 0;
    checks    = 0;
    ops_done  = 0;
    yumi_mode = 0;
    rd_next   = '0;
    clk_i     = 1'b0;
    reset_i   = 1'b1;
    v_i       = 1'b0;
    op_i      = op_fsgnj;
    rs1_i     = '0;
    rs2_i     = '0;
    rd_i      = '0;
    yumi_i    = 1'b0;
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    check_flag("ready_o", ready_o, 1'b1);
    check_flag("v_o", v_o, 1'b0);

    sign_injection();
    min_max_pairs();
    moves_and_converts();
    stream_back_to_back();
    back_pressure_drain();
    reset_mid_stream();

    total_errors = errors + uut.chk.assert_fails;
    $display("tests 6, operations %0d, checks %0d, errors %0d", ops_done, checks,
             total_errors);
    if (total_errors == 0) begin
      $display("=== PASS ===");
    end
    else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
src/fpu_pkg.sv
src/fpu_result_if.sv
src/fpu_float_aux.sv
src/fpu_i2f.sv
src/fpu_float.sv
src/fpu_result_fifo.sv
src/fpu_top.sv
tests/fpu_checker.sv
tests/fpu_tb.sv

// ==== Bender.yml ====
package:
  name: fpu_writeback

sources:
  - src/fpu_pkg.sv
  - src/fpu_result_if.sv
  - src/fpu_float_aux.sv
  - src/fpu_i2f.sv
  - src/fpu_float.sv
  - src/fpu_result_fifo.sv
  - src/fpu_top.sv
  - target: test
    files:
      - tests/fpu_checker.sv
      - tests/fpu_tb.sv
